/* cr16_isa_pkg.sv */
// Instruction field encodings for the CR16-style core
// Opcode 14 (accelerator) and R-type extras 14 and 15 are not decoded here
package cr16_isa_pkg;

    typedef logic [3:0] opcode_t;
    typedef logic [3:0] opcode_extra_t;

    // Primary opcodes
    localparam opcode_t OPCODE_RTYPE  = 4'd0;
    localparam opcode_t OPCODE_ANDI   = 4'd1;
    localparam opcode_t OPCODE_ORI    = 4'd2;
    localparam opcode_t OPCODE_XORI   = 4'd3;
    localparam opcode_t OPCODE_MEMORY = 4'd4;
    localparam opcode_t OPCODE_ADDI   = 4'd5;
    localparam opcode_t OPCODE_LSH    = 4'd8;
    localparam opcode_t OPCODE_SUBI   = 4'd9;
    localparam opcode_t OPCODE_CMPI   = 4'd11;
    localparam opcode_t OPCODE_BCOND  = 4'd12;
    localparam opcode_t OPCODE_MOVI   = 4'd13;
    localparam opcode_t OPCODE_LUI    = 4'd15;

    // R-type extra codes
    localparam opcode_extra_t EXTRA_AND = 4'd1;
    localparam opcode_extra_t EXTRA_OR  = 4'd2;
    localparam opcode_extra_t EXTRA_XOR = 4'd3;
    localparam opcode_extra_t EXTRA_ADD = 4'd5;
    localparam opcode_extra_t EXTRA_SUB = 4'd9;
    localparam opcode_extra_t EXTRA_CMP = 4'd11;
    localparam opcode_extra_t EXTRA_MUL = 4'd12;
    localparam opcode_extra_t EXTRA_MOV = 4'd13;

    // Shift group
    localparam opcode_extra_t EXTRA_LSHI_LEFT = 4'd0;
    localparam opcode_extra_t EXTRA_LSHI_TWO  = 4'd1;
    localparam opcode_extra_t EXTRA_LSH       = 4'd4;

    // Memory and jump group
    localparam opcode_extra_t EXTRA_LOAD  = 4'd0;
    localparam opcode_extra_t EXTRA_STOR  = 4'd4;
    localparam opcode_extra_t EXTRA_JAL   = 4'd8;
    localparam opcode_extra_t EXTRA_JCOND = 4'd12;

    // One value per executable instruction
    typedef enum logic [4:0] {
        OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL,
        OP_CMP, OP_CMPI,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI,
        OP_MOV, OP_MOVI,
        OP_LSH, OP_LSHI,
        OP_LUI,
        OP_LOAD, OP_STOR,
        OP_BCOND, OP_JCOND, OP_JAL,
        OP_ILLEGAL
    } operation_t;

endpackage

/* cr16_control_pkg.sv */
// Phase and datapath select encodings driven by the controller
// Select values must match the mux wiring in the datapath
package cr16_control_pkg;

    typedef enum logic [1:0] {
        PHASE_FETCH   = 2'd0,
        PHASE_DECODE  = 2'd1,
        PHASE_EXECUTE = 2'd2
    } phase_t;

    typedef enum logic [1:0] {
        ALU_A_PROGRAM_COUNTER = 2'd0,
        ALU_A_SOURCE          = 2'd1,
        ALU_A_IMMEDIATE_SIGN  = 2'd2,
        ALU_A_IMMEDIATE_ZERO  = 2'd3
    } alu_a_select_t;

    // Code 1 is unused on this port
    typedef enum logic [1:0] {
        ALU_B_DESTINATION    = 2'd0,
        ALU_B_IMMEDIATE_COND = 2'd2
    } alu_b_select_t;

    typedef enum logic [2:0] {
        ALU_ADD      = 3'd0,
        ALU_SUBTRACT = 3'd1,
        ALU_COMPARE  = 3'd2,
        ALU_AND      = 3'd3,
        ALU_OR       = 3'd4,
        ALU_XOR      = 3'd5,
        ALU_SHIFT    = 3'd6,
        ALU_MULTIPLY = 3'd7
    } alu_operation_t;

    typedef enum logic [1:0] {
        PC_INCREMENT  = 2'd0,
        PC_ALU_RESULT = 2'd1,
        PC_CONDITION  = 2'd2,
        PC_SOURCE     = 2'd3
    } pc_select_t;

    typedef enum logic [2:0] {
        WRITE_ALU_RESULT      = 3'd0,
        WRITE_SOURCE          = 3'd1,
        WRITE_IMMEDIATE_ZERO  = 3'd2,
        WRITE_IMMEDIATE_UPPER = 3'd3,
        WRITE_READ_DATA       = 3'd4,
        WRITE_PC_NEXT         = 3'd5
    } write_data_select_t;

    typedef enum logic {
        ADDRESS_PROGRAM_COUNTER = 1'b0,
        ADDRESS_SOURCE          = 1'b1
    } address_select_t;

endpackage

/* instruction_decoder.sv */
// Purely combinational opcode decode
// Inputs are only meaningful while the sequencer is in DECODE
`timescale 1ns/1ps

module instruction_decoder
    import cr16_isa_pkg::*;
(
    input  opcode_t       instruction_operation,
    input  opcode_extra_t instruction_operation_extra,
    output operation_t    decoded_operation
);

    always_comb
    begin
        decoded_operation = OP_ILLEGAL;
        case (instruction_operation)
            OPCODE_RTYPE:
            begin
                case (instruction_operation_extra)
                    EXTRA_ADD: decoded_operation = OP_ADD;
                    EXTRA_SUB: decoded_operation = OP_SUB;
                    EXTRA_CMP: decoded_operation = OP_CMP;
                    EXTRA_AND: decoded_operation = OP_AND;
                    EXTRA_OR:  decoded_operation = OP_OR;
                    EXTRA_XOR: decoded_operation = OP_XOR;
                    EXTRA_MOV: decoded_operation = OP_MOV;
                    EXTRA_MUL: decoded_operation = OP_MUL;
                    default:   decoded_operation = OP_ILLEGAL;
                endcase
            end
            OPCODE_ANDI:  decoded_operation = OP_ANDI;
            OPCODE_ORI:   decoded_operation = OP_ORI;
            OPCODE_XORI:  decoded_operation = OP_XORI;
            OPCODE_ADDI:  decoded_operation = OP_ADDI;
            OPCODE_SUBI:  decoded_operation = OP_SUBI;
            OPCODE_CMPI:  decoded_operation = OP_CMPI;
            OPCODE_MOVI:  decoded_operation = OP_MOVI;
            OPCODE_LUI:   decoded_operation = OP_LUI;
            OPCODE_BCOND: decoded_operation = OP_BCOND;
            OPCODE_LSH:
            begin
                // Both immediate shift forms share one execute step
                case (instruction_operation_extra)
                    EXTRA_LSH:       decoded_operation = OP_LSH;
                    EXTRA_LSHI_LEFT: decoded_operation = OP_LSHI;
                    EXTRA_LSHI_TWO:  decoded_operation = OP_LSHI;
                    default:         decoded_operation = OP_ILLEGAL;
                endcase
            end
            OPCODE_MEMORY:
            begin
                case (instruction_operation_extra)
                    EXTRA_LOAD:  decoded_operation = OP_LOAD;
                    EXTRA_STOR:  decoded_operation = OP_STOR;
                    EXTRA_JCOND: decoded_operation = OP_JCOND;
                    EXTRA_JAL:   decoded_operation = OP_JAL;
                    default:     decoded_operation = OP_ILLEGAL;
                endcase
            end
            default: decoded_operation = OP_ILLEGAL;
        endcase
    end

endmodule

/* phase_sequencer.sv */
// Three-phase FSM, one instruction in flight
// Illegal codes skip EXECUTE and cost two cycles
`timescale 1ns/1ps

module phase_sequencer
    import cr16_isa_pkg::*;
    import cr16_control_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  operation_t decoded_operation,
    output phase_t     phase,
    output operation_t operation
);

    phase_t phase_next;

    always_comb
    begin
        case (phase)
            PHASE_FETCH:  phase_next = PHASE_DECODE;
            PHASE_DECODE:
            begin
                if (decoded_operation == OP_ILLEGAL)
                    phase_next = PHASE_FETCH;
                else
                    phase_next = PHASE_EXECUTE;
            end
            default:      phase_next = PHASE_FETCH;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            phase     <= PHASE_FETCH;
            operation <= OP_ILLEGAL;
        end
        else
        begin
            phase <= phase_next;
            // Opcode is sampled only as DECODE ends
            if (phase == PHASE_DECODE)
                operation <= decoded_operation;
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        phase == PHASE_EXECUTE |=> phase == PHASE_FETCH)
        else $error("EXECUTE not followed by FETCH");

    assert property (@(posedge clock) disable iff (!reset)
        phase == PHASE_EXECUTE |-> operation != OP_ILLEGAL)
        else $error("EXECUTE entered with an illegal operation");

endmodule

/* datapath_control.sv */
// ALU, status and register file controls, Moore decoded
// All outputs idle at 0 outside EXECUTE
`timescale 1ns/1ps

module datapath_control
    import cr16_isa_pkg::*;
    import cr16_control_pkg::*;
(
    input  phase_t             phase,
    input  operation_t         operation,
    output alu_a_select_t      alu_a_select,
    output alu_b_select_t      alu_b_select,
    output alu_operation_t     alu_operation,
    output logic               status_write_enable,
    output logic               register_write_enable,
    output write_data_select_t register_write_data_select
);

    logic execute;

    assign execute = (phase == PHASE_EXECUTE);

    always_comb
    begin
        alu_a_select = ALU_A_PROGRAM_COUNTER;
        alu_b_select = ALU_B_DESTINATION;
        alu_operation = ALU_ADD;
        register_write_data_select = WRITE_ALU_RESULT;

        if (execute)
        begin
            case (operation)
                OP_ADD, OP_SUB, OP_MUL, OP_CMP, OP_AND, OP_OR, OP_XOR, OP_LSH:
                    alu_a_select = ALU_A_SOURCE;
                OP_ADDI, OP_SUBI, OP_CMPI:
                    alu_a_select = ALU_A_IMMEDIATE_SIGN;
                OP_ANDI, OP_ORI, OP_XORI, OP_LSHI:
                    alu_a_select = ALU_A_IMMEDIATE_ZERO;
                default:
                    alu_a_select = ALU_A_PROGRAM_COUNTER;
            endcase

            // Branch target is PC plus displacement
            if (operation == OP_BCOND)
                alu_b_select = ALU_B_IMMEDIATE_COND;

            case (operation)
                OP_SUB, OP_SUBI:         alu_operation = ALU_SUBTRACT;
                OP_CMP, OP_CMPI:         alu_operation = ALU_COMPARE;
                OP_AND, OP_ANDI:         alu_operation = ALU_AND;
                OP_OR, OP_ORI:           alu_operation = ALU_OR;
                OP_XOR, OP_XORI:         alu_operation = ALU_XOR;
                OP_LSH, OP_LSHI:         alu_operation = ALU_SHIFT;
                OP_MUL:                  alu_operation = ALU_MULTIPLY;
                default:                 alu_operation = ALU_ADD;
            endcase

            case (operation)
                OP_MOV:  register_write_data_select = WRITE_SOURCE;
                OP_MOVI: register_write_data_select = WRITE_IMMEDIATE_ZERO;
                OP_LUI:  register_write_data_select = WRITE_IMMEDIATE_UPPER;
                OP_LOAD: register_write_data_select = WRITE_READ_DATA;
                OP_JAL:  register_write_data_select = WRITE_PC_NEXT;
                default: register_write_data_select = WRITE_ALU_RESULT;
            endcase
        end
    end

    // Flags only from add, subtract and compare
    assign status_write_enable = execute &&
        (operation inside {OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_CMP, OP_CMPI});

    assign register_write_enable = execute &&
        !(operation inside {OP_CMP, OP_CMPI, OP_STOR, OP_BCOND, OP_JCOND, OP_ILLEGAL});

    always_comb
    begin
        assert #0 (!status_write_enable ||
                   alu_operation inside {ALU_ADD, ALU_SUBTRACT, ALU_COMPARE})
            else $error("Status write with a non-arithmetic ALU operation");
    end

endmodule

/* sequencing_control.sv */
// Program counter, instruction register and memory controls
// PC advances once per executed instruction, never on illegal codes
`timescale 1ns/1ps

module sequencing_control
    import cr16_isa_pkg::*;
    import cr16_control_pkg::*;
(
    input  phase_t          phase,
    input  operation_t      operation,
    output logic            program_counter_write_enable,
    output pc_select_t      program_counter_select,
    output logic            instruction_write_enable,
    output logic            memory_write_enable,
    output address_select_t memory_address_select
);

    logic execute;

    assign execute = (phase == PHASE_EXECUTE);

    assign instruction_write_enable = (phase == PHASE_FETCH);
    assign program_counter_write_enable = execute;

    always_comb
    begin
        program_counter_select = PC_INCREMENT;
        if (execute)
        begin
            case (operation)
                OP_BCOND: program_counter_select = PC_ALU_RESULT;
                OP_JCOND: program_counter_select = PC_CONDITION;
                OP_JAL:   program_counter_select = PC_SOURCE;
                default:  program_counter_select = PC_INCREMENT;
            endcase
        end
    end

    // Data accesses address memory through the source register
    always_comb
    begin
        memory_address_select = ADDRESS_PROGRAM_COUNTER;
        if (execute && (operation == OP_LOAD || operation == OP_STOR))
            memory_address_select = ADDRESS_SOURCE;
    end

    assign memory_write_enable = execute && (operation == OP_STOR);

    always_comb
    begin
        assert #0 (!memory_write_enable || memory_address_select == ADDRESS_SOURCE)
            else $error("Memory write with PC address");
    end

endmodule

/* cr16_controller.sv */
// Control unit top for the multicycle CR16-style core
// Outputs are Moore decoded from the registered phase and operation
`timescale 1ns/1ps

module cr16_controller
    import cr16_isa_pkg::*;
    import cr16_control_pkg::*;
(
    input  logic               clock,
    input  logic               reset,
    input  opcode_t            instruction_operation,
    input  opcode_extra_t      instruction_operation_extra,
    output alu_a_select_t      alu_a_select,
    output alu_b_select_t      alu_b_select,
    output alu_operation_t     alu_operation,
    output logic               program_counter_write_enable,
    output pc_select_t         program_counter_select,
    output logic               status_write_enable,
    output logic               instruction_write_enable,
    output logic               register_write_enable,
    output write_data_select_t register_write_data_select,
    output logic               memory_write_enable,
    output address_select_t    memory_address_select
);

    operation_t decoded_operation;
    operation_t operation;
    phase_t     phase;

    instruction_decoder u_instruction_decoder (
        .instruction_operation       (instruction_operation),
        .instruction_operation_extra (instruction_operation_extra),
        .decoded_operation           (decoded_operation)
    );

    phase_sequencer u_phase_sequencer (
        .clock             (clock),
        .reset             (reset),
        .decoded_operation (decoded_operation),
        .phase             (phase),
        .operation         (operation)
    );

    datapath_control u_datapath_control (
        .phase                      (phase),
        .operation                  (operation),
        .alu_a_select               (alu_a_select),
        .alu_b_select               (alu_b_select),
        .alu_operation              (alu_operation),
        .status_write_enable        (status_write_enable),
        .register_write_enable      (register_write_enable),
        .register_write_data_select (register_write_data_select)
    );

    sequencing_control u_sequencing_control (
        .phase                        (phase),
        .operation                    (operation),
        .program_counter_write_enable (program_counter_write_enable),
        .program_counter_select       (program_counter_select),
        .instruction_write_enable     (instruction_write_enable),
        .memory_write_enable          (memory_write_enable),
        .memory_address_select        (memory_address_select)
    );

endmodule

/* tb_instruction_table.svh */
// Expected control outputs one cycle after DECODE for each instruction code
// Illegal rows expect the FETCH outputs, since those codes skip EXECUTE
`ifndef TB_INSTRUCTION_TABLE_SVH
`define TB_INSTRUCTION_TABLE_SVH

typedef struct packed {
    opcode_t            opcode;
    opcode_extra_t      extra;
    logic               legal;
    // Write enables of pc, status, instruction, register, memory
    logic [4:0]         enables;
    alu_a_select_t      alu_a;
    alu_b_select_t      alu_b;
    alu_operation_t     alu_op;
    pc_select_t         pc_select;
    write_data_select_t write_data;
    address_select_t    address;
} table_row_t;

localparam int ROW_COUNT = 29;

table_row_t instruction_table [ROW_COUNT] = '{
    // Arithmetic and compare
    '{OPCODE_RTYPE, EXTRA_ADD, 1'b1, 5'b11010, ALU_A_SOURCE, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_RTYPE, EXTRA_SUB, 1'b1, 5'b11010, ALU_A_SOURCE, ALU_B_DESTINATION,
      ALU_SUBTRACT, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_RTYPE, EXTRA_CMP, 1'b1, 5'b11000, ALU_A_SOURCE, ALU_B_DESTINATION,
      ALU_COMPARE, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_RTYPE, EXTRA_MUL, 1'b1, 5'b10010, ALU_A_SOURCE, ALU_B_DESTINATION,
      ALU_MULTIPLY, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_ADDI, 4'h0, 1'b1, 5'b11010, ALU_A_IMMEDIATE_SIGN, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_SUBI, 4'h7, 1'b1, 5'b11010, ALU_A_IMMEDIATE_SIGN, ALU_B_DESTINATION,
      ALU_SUBTRACT, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_CMPI, 4'hF, 1'b1, 5'b11000, ALU_A_IMMEDIATE_SIGN, ALU_B_DESTINATION,
      ALU_COMPARE, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    // Logic
    '{OPCODE_RTYPE, EXTRA_AND, 1'b1, 5'b10010, ALU_A_SOURCE, ALU_B_DESTINATION,
      ALU_AND, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_RTYPE, EXTRA_OR, 1'b1, 5'b10010, ALU_A_SOURCE, ALU_B_DESTINATION,
      ALU_OR, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_RTYPE, EXTRA_XOR, 1'b1, 5'b10010, ALU_A_SOURCE, ALU_B_DESTINATION,
      ALU_XOR, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_ANDI, 4'h0, 1'b1, 5'b10010, ALU_A_IMMEDIATE_ZERO, ALU_B_DESTINATION,
      ALU_AND, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_ORI, 4'h9, 1'b1, 5'b10010, ALU_A_IMMEDIATE_ZERO, ALU_B_DESTINATION,
      ALU_OR, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_XORI, 4'h3, 1'b1, 5'b10010, ALU_A_IMMEDIATE_ZERO, ALU_B_DESTINATION,
      ALU_XOR, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    // Moves, shifts and upper immediate
    '{OPCODE_RTYPE, EXTRA_MOV, 1'b1, 5'b10010, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_SOURCE, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_MOVI, 4'h0, 1'b1, 5'b10010, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_IMMEDIATE_ZERO, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_LSH, EXTRA_LSH, 1'b1, 5'b10010, ALU_A_SOURCE, ALU_B_DESTINATION,
      ALU_SHIFT, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_LSH, EXTRA_LSHI_LEFT, 1'b1, 5'b10010, ALU_A_IMMEDIATE_ZERO, ALU_B_DESTINATION,
      ALU_SHIFT, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_LSH, EXTRA_LSHI_TWO, 1'b1, 5'b10010, ALU_A_IMMEDIATE_ZERO, ALU_B_DESTINATION,
      ALU_SHIFT, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_LUI, 4'h0, 1'b1, 5'b10010, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_IMMEDIATE_UPPER, ADDRESS_PROGRAM_COUNTER},
    // Memory and control flow
    '{OPCODE_MEMORY, EXTRA_LOAD, 1'b1, 5'b10010, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_READ_DATA, ADDRESS_SOURCE},
    '{OPCODE_MEMORY, EXTRA_STOR, 1'b1, 5'b10001, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_SOURCE},
    '{OPCODE_BCOND, 4'h3, 1'b1, 5'b10000, ALU_A_PROGRAM_COUNTER, ALU_B_IMMEDIATE_COND,
      ALU_ADD, PC_ALU_RESULT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_MEMORY, EXTRA_JCOND, 1'b1, 5'b10000, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_CONDITION, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_MEMORY, EXTRA_JAL, 1'b1, 5'b10010, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_SOURCE, WRITE_PC_NEXT, ADDRESS_PROGRAM_COUNTER},
    // Illegal codes fall straight back to FETCH
    '{4'hA, 4'h0, 1'b0, 5'b00100, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{4'h6, 4'h5, 1'b0, 5'b00100, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{4'h7, 4'hC, 1'b0, 5'b00100, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_RTYPE, 4'hE, 1'b0, 5'b00100, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER},
    '{OPCODE_RTYPE, 4'hF, 1'b0, 5'b00100, ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION,
      ALU_ADD, PC_INCREMENT, WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER}
};

`endif

/* tb_cr16_controller.sv */
// Walks the instruction table through FETCH, DECODE and EXECUTE
// Outputs are sampled on the falling edge, inputs change on the rising edge
`timescale 1ns/1ps

module tb_cr16_controller
    import cr16_isa_pkg::*;
    import cr16_control_pkg::*;
();

    logic               clock;
    logic               reset;
    opcode_t            instruction_operation;
    opcode_extra_t      instruction_operation_extra;
    alu_a_select_t      alu_a_select;
    alu_b_select_t      alu_b_select;
    alu_operation_t     alu_operation;
    pc_select_t         program_counter_select;
    write_data_select_t register_write_data_select;
    address_select_t    memory_address_select;
    logic               program_counter_write_enable;
    logic               status_write_enable;
    logic               instruction_write_enable;
    logic               register_write_enable;
    logic               memory_write_enable;
    int                 errors;
    int                 row_index;
    string              current_phase;
    logic [31:0]        random_state;

    `include "tb_instruction_table.svh"

    localparam int CLOCK_PERIOD = 10;
    localparam int WATCHDOG_CYCLES = ROW_COUNT * 3 + 4 + 20;

    // Only the instruction register loads in FETCH, nothing at all in DECODE
    localparam table_row_t FETCH_OUTPUTS = '{4'h0, 4'h0, 1'b0, 5'b00100,
        ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION, ALU_ADD, PC_INCREMENT,
        WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER};
    localparam table_row_t DECODE_OUTPUTS = '{4'h0, 4'h0, 1'b0, 5'b00000,
        ALU_A_PROGRAM_COUNTER, ALU_B_DESTINATION, ALU_ADD, PC_INCREMENT,
        WRITE_ALU_RESULT, ADDRESS_PROGRAM_COUNTER};

    cr16_controller dut (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        value = value ^ (value << 13);
        value = value ^ (value >> 17);
        return value ^ (value << 5);
    endfunction

    task automatic report_mismatch(input string name, input logic [7:0] actual, expected);
        errors++;
        $display("Mismatch %s in %s of row %0d: got %h, expected %h",
                 name, current_phase, row_index, actual, expected);
    endtask

    task automatic check_bit(input string name, input logic actual, expected);
        if (actual !== expected) report_mismatch(name, actual, expected);
    endtask
    task automatic check_alu_a(input string name, input alu_a_select_t actual, expected);
        if (actual !== expected) report_mismatch(name, actual, expected);
    endtask
    task automatic check_alu_b(input string name, input alu_b_select_t actual, expected);
        if (actual !== expected) report_mismatch(name, actual, expected);
    endtask
    task automatic check_alu_operation(input string name, input alu_operation_t actual, expected);
        if (actual !== expected) report_mismatch(name, actual, expected);
    endtask
    task automatic check_pc_select(input string name, input pc_select_t actual, expected);
        if (actual !== expected) report_mismatch(name, actual, expected);
    endtask
    task automatic check_write_data_select(input string name,
                                           input write_data_select_t actual, expected);
        if (actual !== expected) report_mismatch(name, actual, expected);
    endtask
    task automatic check_address_select(input string name, input address_select_t actual, expected);
        if (actual !== expected) report_mismatch(name, actual, expected);
    endtask

    // Junk opcodes must not reach the latched operation
    task automatic drive_junk_code();
        random_state = xorshift(random_state);
        instruction_operation <= random_state[3:0];
        instruction_operation_extra <= random_state[7:4];
    endtask

    task automatic compare_outputs(input string phase_name, input table_row_t expected);
        current_phase = phase_name;
        check_bit("program_counter_write_enable", program_counter_write_enable,
                  expected.enables[4]);
        check_bit("status_write_enable", status_write_enable, expected.enables[3]);
        check_bit("instruction_write_enable", instruction_write_enable, expected.enables[2]);
        check_bit("register_write_enable", register_write_enable, expected.enables[1]);
        check_bit("memory_write_enable", memory_write_enable, expected.enables[0]);
        check_alu_a("alu_a_select", alu_a_select, expected.alu_a);
        check_alu_b("alu_b_select", alu_b_select, expected.alu_b);
        check_alu_operation("alu_operation", alu_operation, expected.alu_op);
        check_pc_select("program_counter_select", program_counter_select, expected.pc_select);
        check_write_data_select("register_write_data_select", register_write_data_select,
                                expected.write_data);
        check_address_select("memory_address_select", memory_address_select, expected.address);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the controller did not finish %0d rows in time", ROW_COUNT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        clock = 1'b0;
        reset = 1'b0;
        instruction_operation = '0;
        instruction_operation_extra = '0;
        errors = 0;
        row_index = 0;
        random_state = 32'h9996;
        repeat (4) @(posedge clock);
        reset <= 1'b1;
        drive_junk_code();
        @(negedge clock);
        compare_outputs("FETCH after reset", FETCH_OUTPUTS);
        for (row_index = 0; row_index < ROW_COUNT; row_index++)
        begin
            @(posedge clock);
            instruction_operation <= instruction_table[row_index].opcode;
            instruction_operation_extra <= instruction_table[row_index].extra;
            @(negedge clock);
            compare_outputs("DECODE", DECODE_OUTPUTS);
            @(posedge clock);
            drive_junk_code();
            @(negedge clock);
            compare_outputs("cycle after DECODE", instruction_table[row_index]);
            if (instruction_table[row_index].legal)
            begin
                @(posedge clock);
                drive_junk_code();
                @(negedge clock);
                compare_outputs("FETCH after EXECUTE", FETCH_OUTPUTS);
            end
        end
        $display("Checked %0d rows, %0d errors", ROW_COUNT, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
cr16_isa_pkg.sv
cr16_control_pkg.sv
instruction_decoder.sv
phase_sequencer.sv
datapath_control.sv
sequencing_control.sv
cr16_controller.sv
tb_cr16_controller.sv
